/* aes_wrap_macros.svh */
// AES wrapper glue widths and counts
// Shared by the package, the register bus and every RTL block

`ifndef AES_WRAP_MACROS_SVH
`define AES_WRAP_MACROS_SVH

// ============================================================
// Register bus
// ============================================================

// Register byte address width
`define AES_WRAP_ADDR_W 12
// Bus word width
`define AES_WRAP_DATA_W 32

// ============================================================
// Key and seed storage
// ============================================================

// 8 words of 32 bits, 256-bit key
`define AES_WRAP_KEY_WORDS 8
// Key word offset from the key vault
`define AES_WRAP_KEY_OFS_W 3
// 9 words of 32 bits, 288-bit seed state
`define AES_WRAP_SEED_WORDS 9

`endif

/* aes_wrap_pkg.sv */
// AES wrapper glue types
// Register map and requester classification

`default_nettype none

`include "aes_wrap_macros.svh"

package aes_wrap_pkg;

  // Register byte addresses
  typedef enum logic [`AES_WRAP_ADDR_W-1:0] {
    CTRL       = 12'h000,  // Bit 0 endian swap enable
    KEY_CTRL   = 12'h004,  // Bit 0 starts a key read
    KEY_STATUS = 12'h008,  // Bit 0 key valid
    // Data window, swappable
    DATA_IN_0  = 12'h010,
    DATA_IN_1  = 12'h014,
    DATA_IN_2  = 12'h018,
    DATA_IN_3  = 12'h01C,
    // Seed words, write only
    SEED_0     = 12'h020,
    SEED_1     = 12'h024,
    SEED_2     = 12'h028,
    SEED_3     = 12'h02C,
    SEED_4     = 12'h030,
    SEED_5     = 12'h034,
    SEED_6     = 12'h038,
    SEED_7     = 12'h03C,
    SEED_8     = 12'h040
  } reg_addr_e;

  // Requests present in a cycle, encoded as {dma, host}
  typedef enum logic [1:0] {
    SRC_NONE = 2'b00,
    SRC_HOST = 2'b01,
    SRC_DMA  = 2'b10,
    SRC_BOTH = 2'b11
  } req_src_e;

endpackage

`default_nettype wire

/* reg_bus_if.sv */
// Internal register bus between requester mux and register file
// Single-cycle access, no handshake

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

interface reg_bus_if;

  // Request side
  logic                        dv;
  logic                        write;
  logic [`AES_WRAP_ADDR_W-1:0] addr;
  logic [`AES_WRAP_DATA_W-1:0] wdata;

  // Response, valid in the dv cycle
  logic [`AES_WRAP_DATA_W-1:0] rdata;
  // Unmapped address
  logic                        error;

  // Requester mux side
  modport mux_mp (
    output dv, write, addr, wdata,
    input  rdata, error
  );

  // Register file side
  modport regs_mp (
    input  dv, write, addr, wdata,
    output rdata, error
  );

endinterface

`default_nettype wire

/* cif_req_mux.sv */
// Host/DMA request mux onto the register bus
// Flags collisions and byte-swaps the data window when enabled

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module cif_req_mux
  import aes_wrap_pkg::*;
(
  // Host requester
  input  wire logic                        host_dv_i,
  input  wire logic                        host_write_i,
  input  wire logic [`AES_WRAP_ADDR_W-1:0] host_addr_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0] host_wdata_i,
  output logic      [`AES_WRAP_DATA_W-1:0] host_rdata_o,
  output logic                             host_error_o,
  // DMA requester
  input  wire logic                        dma_dv_i,
  input  wire logic                        dma_write_i,
  input  wire logic [`AES_WRAP_ADDR_W-1:0] dma_addr_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0] dma_wdata_i,
  output logic      [`AES_WRAP_DATA_W-1:0] dma_rdata_o,
  output logic                             dma_error_o,
  // From CTRL bit 0
  input  wire logic                        endian_swap_i,
  reg_bus_if.mux_mp                        bus
);

  req_src_e                    req_src;
  logic                        collision;
  logic                        sel_write;
  logic [`AES_WRAP_ADDR_W-1:0] sel_addr;
  logic [`AES_WRAP_DATA_W-1:0] sel_wdata;
  logic                        swap_en;
  logic [`AES_WRAP_DATA_W-1:0] rdata_post;

  // Reverse byte order of one bus word
  function automatic logic [`AES_WRAP_DATA_W-1:0] byte_swap(
    input logic [`AES_WRAP_DATA_W-1:0] word
  );
    logic [`AES_WRAP_DATA_W-1:0] res;
    for (int b = 0; b < `AES_WRAP_DATA_W / 8; b++) begin
      res[b*8 +: 8] = word[(`AES_WRAP_DATA_W/8 - 1 - b)*8 +: 8];
    end
    return res;
  endfunction

  // ============================================================
  // Requester select
  // ============================================================

  always_comb begin
    req_src   = req_src_e'({dma_dv_i, host_dv_i});
    sel_write = 1'b0;
    sel_addr  = '0;
    sel_wdata = '0;
    case (req_src)
      SRC_HOST: begin
        sel_write = host_write_i;
        sel_addr  = host_addr_i;
        sel_wdata = host_wdata_i;
      end
      SRC_DMA: begin
        sel_write = dma_write_i;
        sel_addr  = dma_addr_i;
        sel_wdata = dma_wdata_i;
      end
      // Idle or collision, nothing forwarded
      default: ;
    endcase
  end

  // Firmware must keep the two requesters apart
  assign collision = (req_src == SRC_BOTH);

  // Swap only on the data window
  assign swap_en = endian_swap_i &&
                   (sel_addr inside {DATA_IN_0, DATA_IN_1, DATA_IN_2, DATA_IN_3});

  assign bus.dv    = (req_src == SRC_HOST) || (req_src == SRC_DMA);
  assign bus.write = sel_write;
  assign bus.addr  = sel_addr;
  assign bus.wdata = swap_en ? byte_swap(sel_wdata) : sel_wdata;

  // ============================================================
  // Responses
  // ============================================================

  assign rdata_post = swap_en ? byte_swap(bus.rdata) : bus.rdata;

  // Zero unless this requester owns the bus
  assign host_rdata_o = (req_src == SRC_HOST) ? rdata_post : '0;
  assign dma_rdata_o  = (req_src == SRC_DMA) ? rdata_post : '0;

  // Collision errors both, decode error only the owner
  assign host_error_o = collision || ((req_src == SRC_HOST) && bus.error);
  assign dma_error_o  = collision || ((req_src == SRC_DMA) && bus.error);

  // Colliding requests must never reach the register file
  always_comb begin
    a_no_dv_on_collision : assert final (!(bus.dv && host_dv_i && dma_dv_i));
  end

endmodule

`default_nettype wire

/* aes_wrap_regs.sv */
// AES wrapper register file
// CTRL, key control and status, data window and seed words

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module aes_wrap_regs
  import aes_wrap_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset_n,
  reg_bus_if.regs_mp bus,
  // Key status from the loader
  input  wire logic  key_valid_i,
  output logic       endian_swap_o,
  // One-cycle pulse, cycle after the KEY_CTRL write
  output logic       key_read_req_o,
  // Seed words to the entropy buffer, SEED_0 in the low word
  output logic [`AES_WRAP_SEED_WORDS*`AES_WRAP_DATA_W-1:0] seed_o,
  output logic [`AES_WRAP_SEED_WORDS-1:0]                  seed_wr_o
);

  localparam int SEED_IDX_W = $clog2(`AES_WRAP_SEED_WORDS);

  // Storage
  logic                                              swap_q;
  logic                                              key_req_q;
  logic [3:0][`AES_WRAP_DATA_W-1:0]                  data_q;
  logic [`AES_WRAP_SEED_WORDS-1:0][`AES_WRAP_DATA_W-1:0] seed_q;

  // Decode
  logic                        wr_en;
  logic                        mapped;
  logic                        ctrl_hit;
  logic                        kctrl_hit;
  logic                        data_hit;
  logic                        seed_hit;
  logic [1:0]                  data_idx;
  logic [`AES_WRAP_ADDR_W-1:0] seed_ofs;
  logic [SEED_IDX_W-1:0]       seed_idx;

  assign wr_en    = bus.dv && bus.write;
  // Word index within each block
  assign data_idx = bus.addr[3:2];
  assign seed_ofs = bus.addr - SEED_0;
  assign seed_idx = seed_ofs[2 +: SEED_IDX_W];

  // ============================================================
  // Address decode and read mux
  // ============================================================

  always_comb begin
    mapped    = 1'b1;
    ctrl_hit  = 1'b0;
    kctrl_hit = 1'b0;
    data_hit  = 1'b0;
    seed_hit  = 1'b0;
    bus.rdata = '0;
    case (bus.addr)
      CTRL: begin
        ctrl_hit  = 1'b1;
        bus.rdata = {{(`AES_WRAP_DATA_W-1){1'b0}}, swap_q};
      end
      // Start bit is self-clearing, reads zero
      KEY_CTRL: kctrl_hit = 1'b1;
      KEY_STATUS: bus.rdata = {{(`AES_WRAP_DATA_W-1){1'b0}}, key_valid_i};
      DATA_IN_0, DATA_IN_1, DATA_IN_2, DATA_IN_3: begin
        data_hit  = 1'b1;
        bus.rdata = data_q[data_idx];
      end
      // Seed words read as zero
      SEED_0, SEED_1, SEED_2, SEED_3, SEED_4, SEED_5, SEED_6, SEED_7, SEED_8: begin
        seed_hit = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign bus.error = bus.dv && !mapped;

  // Seed strobes land at the same edge as the write
  always_comb begin
    seed_wr_o = '0;
    if (wr_en && seed_hit) begin
      seed_wr_o[seed_idx] = 1'b1;
    end
  end

  // ============================================================
  // Register updates
  // ============================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      swap_q    <= 1'b0;
      key_req_q <= 1'b0;
      data_q    <= '0;
      seed_q    <= '0;
    end else begin
      // Pulse from a write of 1 to KEY_CTRL bit 0
      key_req_q <= wr_en && kctrl_hit && bus.wdata[0];
      if (wr_en && ctrl_hit) begin
        swap_q <= bus.wdata[0];
      end
      if (wr_en && data_hit) begin
        data_q[data_idx] <= bus.wdata;
      end
      if (wr_en && seed_hit) begin
        seed_q[seed_idx] <= bus.wdata;
      end
    end
  end

  assign endian_swap_o  = swap_q;
  assign key_read_req_o = key_req_q;
  assign seed_o         = seed_q;

endmodule

`default_nettype wire

/* key_load.sv */
// Key vault word capture with byte swizzle into a 256-bit key
// Keeps the key-valid sideband for the AES engine

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module key_load (
  input  wire logic                          clk,
  input  wire logic                          reset_n,
  // New key request, invalidates the held key
  input  wire logic                          key_read_req_i,
  // Key vault read stream
  input  wire logic                          kv_wr_en_i,
  input  wire logic [`AES_WRAP_KEY_OFS_W-1:0] kv_ofs_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0]    kv_data_i,
  input  wire logic                          kv_done_i,
  input  wire logic                          kv_error_i,
  input  wire logic                          zeroize_i,
  output logic                               key_valid_o,
  output logic [`AES_WRAP_KEY_WORDS*`AES_WRAP_DATA_W-1:0] key_o
);

  logic [`AES_WRAP_KEY_WORDS-1:0][`AES_WRAP_DATA_W-1:0] key_q;
  logic [`AES_WRAP_DATA_W-1:0]                         kv_data_swz;
  logic                                                valid_q;
  logic                                                invalidate;

  // Vault words are big endian, engine wants little endian
  always_comb begin
    for (int b = 0; b < `AES_WRAP_DATA_W / 8; b++) begin
      kv_data_swz[b*8 +: 8] = kv_data_i[(`AES_WRAP_DATA_W/8 - 1 - b)*8 +: 8];
    end
  end

  // Key words
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q <= '0;
    end else if (zeroize_i) begin
      key_q <= '0;
    end else if (kv_wr_en_i) begin
      key_q[kv_ofs_i] <= kv_data_swz;
    end
  end

  // Clearing wins over done
  assign invalidate = key_read_req_i || kv_error_i || zeroize_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
    end else if (invalidate) begin
      valid_q <= 1'b0;
    end else if (kv_done_i) begin
      valid_q <= 1'b1;
    end
  end

  assign key_valid_o = valid_q;
  assign key_o       = key_q;

  // Vault must not stream words while the key is being wiped
  a_no_wr_on_zeroize : assert property (
    @(posedge clk) disable iff (!reset_n) !(kv_wr_en_i && zeroize_i)
  );

endmodule

`default_nettype wire

/* entropy_seed_buffer.sv */
// Rotating seed buffer feeding 32-bit entropy words
// Reseeds once firmware has written all nine seed words

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module entropy_seed_buffer (
  input  wire logic clk,
  input  wire logic reset_n,
  input  wire logic [`AES_WRAP_SEED_WORDS*`AES_WRAP_DATA_W-1:0] seed_i,
  input  wire logic [`AES_WRAP_SEED_WORDS-1:0]                  seed_wr_i,
  input  wire logic                                             entropy_req_i,
  output logic      [`AES_WRAP_DATA_W-1:0]                      entropy_o
);

  // Which seed words were written since the last reseed
  logic [`AES_WRAP_SEED_WORDS-1:0]                  seed_vld_q;
  logic                                             reseed;
  logic [`AES_WRAP_SEED_WORDS*`AES_WRAP_DATA_W-1:0] state_q;

  assign reseed = &seed_vld_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_vld_q <= '0;
    end else if (reseed) begin
      seed_vld_q <= '0;
    end else begin
      seed_vld_q <= seed_vld_q | seed_wr_i;
    end
  end

  // Reseed wins over a request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= '0;
    end else if (reseed) begin
      state_q <= seed_i;
    end else if (entropy_req_i) begin
      // Rotate right by one word
      state_q <= {state_q[`AES_WRAP_DATA_W-1:0],
                  state_q[`AES_WRAP_SEED_WORDS*`AES_WRAP_DATA_W-1:`AES_WRAP_DATA_W]};
    end
  end

  assign entropy_o = state_q[`AES_WRAP_DATA_W-1:0];

  // Tracking restarts after every reseed
  a_flags_clear_after_reseed : assert property (
    @(posedge clk) disable iff (!reset_n) reseed |=> (seed_vld_q == '0)
  );

endmodule

`default_nettype wire

/* aes_wrap_top.sv */
// AES wrapper host-side glue top level
// Request mux, registers, key loading and entropy buffer on plain ports

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module aes_wrap_top (
  input  wire logic                           clk,
  input  wire logic                           reset_n,
  // Host requester
  input  wire logic                           host_dv_i,
  input  wire logic                           host_write_i,
  input  wire logic [`AES_WRAP_ADDR_W-1:0]    host_addr_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0]    host_wdata_i,
  output logic      [`AES_WRAP_DATA_W-1:0]    host_rdata_o,
  output logic                                host_error_o,
  // DMA requester
  input  wire logic                           dma_dv_i,
  input  wire logic                           dma_write_i,
  input  wire logic [`AES_WRAP_ADDR_W-1:0]    dma_addr_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0]    dma_wdata_i,
  output logic      [`AES_WRAP_DATA_W-1:0]    dma_rdata_o,
  output logic                                dma_error_o,
  // Key vault read stream
  input  wire logic                           kv_wr_en_i,
  input  wire logic [`AES_WRAP_KEY_OFS_W-1:0] kv_ofs_i,
  input  wire logic [`AES_WRAP_DATA_W-1:0]    kv_data_i,
  input  wire logic                           kv_done_i,
  input  wire logic                           kv_error_i,
  input  wire logic                           zeroize_i,
  // Entropy request from the engine
  input  wire logic                           entropy_req_i,
  output logic                                key_read_req_o,
  output logic                                key_valid_o,
  output logic [`AES_WRAP_KEY_WORDS*`AES_WRAP_DATA_W-1:0] key_o,
  output logic [`AES_WRAP_DATA_W-1:0]                     entropy_o
);

  reg_bus_if bus_if ();

  logic                                             endian_swap;
  logic [`AES_WRAP_SEED_WORDS*`AES_WRAP_DATA_W-1:0] seed;
  logic [`AES_WRAP_SEED_WORDS-1:0]                  seed_wr;

  // ============================================================
  // Register path
  // ============================================================

  cif_req_mux i_cif_req_mux (
    .host_dv_i     (host_dv_i),
    .host_write_i  (host_write_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o),
    .host_error_o  (host_error_o),
    .dma_dv_i      (dma_dv_i),
    .dma_write_i   (dma_write_i),
    .dma_addr_i    (dma_addr_i),
    .dma_wdata_i   (dma_wdata_i),
    .dma_rdata_o   (dma_rdata_o),
    .dma_error_o   (dma_error_o),
    .endian_swap_i (endian_swap),
    .bus           (bus_if.mux_mp)
  );

  aes_wrap_regs i_aes_wrap_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .bus            (bus_if.regs_mp),
    .key_valid_i    (key_valid_o),
    .endian_swap_o  (endian_swap),
    .key_read_req_o (key_read_req_o),
    .seed_o         (seed),
    .seed_wr_o      (seed_wr)
  );

  // ============================================================
  // Key and entropy sidebands
  // ============================================================

  key_load i_key_load (
    .clk            (clk),
    .reset_n        (reset_n),
    .key_read_req_i (key_read_req_o),
    .kv_wr_en_i     (kv_wr_en_i),
    .kv_ofs_i       (kv_ofs_i),
    .kv_data_i      (kv_data_i),
    .kv_done_i      (kv_done_i),
    .kv_error_i     (kv_error_i),
    .zeroize_i      (zeroize_i),
    .key_valid_o    (key_valid_o),
    .key_o          (key_o)
  );

  entropy_seed_buffer i_entropy_seed_buffer (
    .clk           (clk),
    .reset_n       (reset_n),
    .seed_i        (seed),
    .seed_wr_i     (seed_wr),
    .entropy_req_i (entropy_req_i),
    .entropy_o     (entropy_o)
  );

endmodule

`default_nettype wire

/* tb_aes_wrap.sv */
// Testbench for the AES wrapper host-side glue
// Register access, key loading and entropy reseed against a local model

`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_macros.svh"

module tb_aes_wrap
  import aes_wrap_pkg::*;
;

  // Run limit in clock cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        reset_n;
  logic        host_dv_i;
  logic        host_write_i;
  logic [11:0] host_addr_i;
  logic [31:0] host_wdata_i;
  logic [31:0] host_rdata_o;
  logic        host_error_o;
  logic        dma_dv_i;
  logic        dma_write_i;
  logic [11:0] dma_addr_i;
  logic [31:0] dma_wdata_i;
  logic [31:0] dma_rdata_o;
  logic        dma_error_o;
  logic        kv_wr_en_i;
  logic [2:0]  kv_ofs_i;
  logic [31:0] kv_data_i;
  logic        kv_done_i;
  logic        kv_error_i;
  logic        zeroize_i;
  logic        entropy_req_i;
  logic        key_read_req_o;
  logic        key_valid_o;
  logic [255:0] key_o;
  logic [31:0] entropy_o;

  // Model state
  logic [31:0]  lfsr_q;
  logic [31:0]  data_words [4];
  logic [31:0]  seed_model [9];
  logic [8:0]   covered;
  logic [255:0] key_exp;
  int           cycle_cnt;
  int           fail_count;

  aes_wrap_top i_aes_wrap_top (
    .clk, .reset_n,
    .host_dv_i, .host_write_i, .host_addr_i, .host_wdata_i, .host_rdata_o, .host_error_o,
    .dma_dv_i, .dma_write_i, .dma_addr_i, .dma_wdata_i, .dma_rdata_o, .dma_error_o,
    .kv_wr_en_i, .kv_ofs_i, .kv_data_i, .kv_done_i, .kv_error_i, .zeroize_i,
    .entropy_req_i, .key_read_req_o, .key_valid_o, .key_o, .entropy_o
  );

  // ============================================================
  // Clock, timeout and error reporting
  // ============================================================

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("timeout, tests did not finish within the cycle limit");
    end
  end

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    fail_count = fail_count + 1;
    $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_failure(input string what);
    fail_count = fail_count + 1;
    $display("ERROR at %0t ns: %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    a_word : assert (got === exp)
      else report_mismatch(name, {224'b0, got}, {224'b0, exp});
  endtask

  // Both requesters see the collision
  a_collision_errors : assert property (
    @(negedge clk) disable iff (!reset_n)
    (host_dv_i && dma_dv_i) |-> (host_error_o && dma_error_o)
  ) else report_mismatch("host_error_o,dma_error_o", {254'b0, host_error_o, dma_error_o},
                         256'd3);

  // Idle requesters get zero responses
  a_host_idle_quiet : assert property (
    @(negedge clk) disable iff (!reset_n)
    !host_dv_i |-> (host_rdata_o == 32'b0 && !host_error_o)
  ) else report_mismatch("host_rdata_o,host_error_o", {223'b0, host_rdata_o, host_error_o},
                         256'd0);

  a_dma_idle_quiet : assert property (
    @(negedge clk) disable iff (!reset_n)
    !dma_dv_i |-> (dma_rdata_o == 32'b0 && !dma_error_o)
  ) else report_mismatch("dma_rdata_o,dma_error_o", {223'b0, dma_rdata_o, dma_error_o},
                         256'd0);

  // Key read request lasts one cycle
  a_key_req_single : assert property (
    @(posedge clk) disable iff (!reset_n) key_read_req_o |=> !key_read_req_o
  ) else report_mismatch("key_read_req_o", 256'd1, 256'd0);

  // ============================================================
  // Stimulus helpers
  // ============================================================

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] val);
    val = 32'b0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Error output of the requester that made the access
  function automatic string error_port_name(input logic from_dma);
    if (from_dma) begin
      return "dma_error_o";
    end else begin
      return "host_error_o";
    end
  endfunction

  // Single access with the response sampled mid-cycle
  task automatic access(input logic from_dma, input logic wr, input logic [11:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic err);
    @(posedge clk);
    if (from_dma) begin
      dma_dv_i    <= 1'b1;
      dma_write_i <= wr;
      dma_addr_i  <= addr;
      dma_wdata_i <= wdata;
    end else begin
      host_dv_i    <= 1'b1;
      host_write_i <= wr;
      host_addr_i  <= addr;
      host_wdata_i <= wdata;
    end
    @(negedge clk);
    rdata = from_dma ? dma_rdata_o : host_rdata_o;
    err   = from_dma ? dma_error_o : host_error_o;
    @(posedge clk);
    host_dv_i    <= 1'b0;
    host_write_i <= 1'b0;
    dma_dv_i     <= 1'b0;
    dma_write_i  <= 1'b0;
  endtask

  task automatic write_reg(input logic from_dma, input logic [11:0] addr,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    access(from_dma, 1'b1, addr, wdata, rdata, err);
    expect_word(error_port_name(from_dma), {31'b0, err}, 32'd0);
  endtask

  task automatic read_reg(input logic from_dma, input logic [11:0] addr,
                          input logic [31:0] exp, input string name);
    logic [31:0] rdata;
    logic        err;
    access(from_dma, 1'b0, addr, 32'b0, rdata, err);
    expect_word(error_port_name(from_dma), {31'b0, err}, 32'd0);
    expect_word(name, rdata, exp);
  endtask

  // KEY_CTRL start pulses the request one cycle after the write
  task automatic request_key(input logic valid_before);
    write_reg(1'b0, KEY_CTRL, 32'd1);
    @(negedge clk);
    expect_word("key_read_req_o", {31'b0, key_read_req_o}, 32'd1);
    expect_word("key_valid_o", {31'b0, key_valid_o}, {31'b0, valid_before});
    @(negedge clk);
    expect_word("key_read_req_o", {31'b0, key_read_req_o}, 32'd0);
    expect_word("key_valid_o", {31'b0, key_valid_o}, 32'd0);
  endtask

  task automatic load_key();
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      rand_bits(32, w);
      key_exp[i*32 +: 32] = reverse_bytes(w);
      @(posedge clk);
      kv_wr_en_i <= 1'b1;
      kv_ofs_i   <= 3'(i);
      kv_data_i  <= w;
    end
    @(posedge clk);
    kv_wr_en_i <= 1'b0;
    kv_done_i  <= 1'b1;
    @(negedge clk);
    expect_word("key_valid_o", {31'b0, key_valid_o}, 32'd0);
    @(posedge clk);
    kv_done_i <= 1'b0;
    @(negedge clk);
    expect_word("key_valid_o", {31'b0, key_valid_o}, 32'd1);
    a_key : assert (key_o === key_exp) else report_mismatch("key_o", key_o, key_exp);
  endtask

  // One-cycle clear strobe, or kv_error racing a done
  task automatic strobe_clear(input logic use_zeroize);
    @(posedge clk);
    if (use_zeroize) begin
      zeroize_i <= 1'b1;
    end else begin
      kv_error_i <= 1'b1;
      kv_done_i  <= 1'b1;
    end
    @(negedge clk);
    expect_word("key_valid_o", {31'b0, key_valid_o}, 32'd1);
    @(posedge clk);
    zeroize_i  <= 1'b0;
    kv_error_i <= 1'b0;
    kv_done_i  <= 1'b0;
    @(negedge clk);
    expect_word("key_valid_o", {31'b0, key_valid_o}, 32'd0);
  endtask

  // Reseed shows one cycle after the last seed flag
  task automatic write_seed(input int idx);
    logic [31:0] w;
    rand_bits(32, w);
    seed_model[idx] = w;
    write_reg(1'b0, SEED_0 + 12'(4*idx), w);
    covered[idx] = 1'b1;
    @(negedge clk);
    expect_word("entropy_o", entropy_o, 32'd0);
    if (covered == 9'h1FF) begin
      @(negedge clk);
      expect_word("entropy_o", entropy_o, seed_model[0]);
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    logic [31:0] r;
    logic [31:0] rdata;
    logic        err;
    int          n;
    reset_n       = 1'b0;
    host_dv_i     = 1'b0;
    host_write_i  = 1'b0;
    host_addr_i   = 12'b0;
    host_wdata_i  = 32'b0;
    dma_dv_i      = 1'b0;
    dma_write_i   = 1'b0;
    dma_addr_i    = 12'b0;
    dma_wdata_i   = 32'b0;
    kv_wr_en_i    = 1'b0;
    kv_ofs_i      = 3'b0;
    kv_data_i     = 32'b0;
    kv_done_i     = 1'b0;
    kv_error_i    = 1'b0;
    zeroize_i     = 1'b0;
    entropy_req_i = 1'b0;
    lfsr_q        = 32'd93448;
    covered       = 9'b0;
    key_exp       = 256'b0;
    cycle_cnt     = 0;
    fail_count    = 0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    // Host writes the data window and DMA reads it back with swap off and on
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, data_words[i]);
      write_reg(1'b0, DATA_IN_0 + 12'(4*i), data_words[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(1'b1, DATA_IN_0 + 12'(4*i), data_words[i], "dma_rdata_o");
    end
    write_reg(1'b0, CTRL, 32'd1);
    read_reg(1'b1, CTRL, 32'd1, "dma_rdata_o");
    for (int i = 0; i < 4; i++) begin
      read_reg(1'b1, DATA_IN_0 + 12'(4*i), reverse_bytes(data_words[i]), "dma_rdata_o");
    end
    write_reg(1'b0, CTRL, 32'd0);

    // Collision leaves DATA_IN_0 untouched
    rand_bits(32, r);
    @(posedge clk);
    host_dv_i    <= 1'b1;
    host_write_i <= 1'b1;
    host_addr_i  <= DATA_IN_0;
    host_wdata_i <= r;
    dma_dv_i     <= 1'b1;
    dma_write_i  <= 1'b1;
    dma_addr_i   <= DATA_IN_0;
    dma_wdata_i  <= ~r;
    @(posedge clk);
    host_dv_i    <= 1'b0;
    host_write_i <= 1'b0;
    dma_dv_i     <= 1'b0;
    dma_write_i  <= 1'b0;
    read_reg(1'b1, DATA_IN_0, data_words[0], "dma_rdata_o");

    // Unmapped addresses raise only the owner's error
    access(1'b0, 1'b0, 12'h100, 32'b0, rdata, err);
    expect_word("host_error_o", {31'b0, err}, 32'd1);
    access(1'b1, 1'b1, 12'h044, 32'hFFFF_FFFF, rdata, err);
    expect_word("dma_error_o", {31'b0, err}, 32'd1);

    // Key request, load and invalidation
    request_key(1'b0);
    load_key();
    read_reg(1'b0, KEY_STATUS, 32'd1, "host_rdata_o");
    request_key(1'b1);
    read_reg(1'b0, KEY_STATUS, 32'd0, "host_rdata_o");
    load_key();
    strobe_clear(1'b0);
    load_key();
    strobe_clear(1'b1);
    a_key_zero : assert (key_o === 256'b0) else report_mismatch("key_o", key_o, 256'b0);

    // Seed words in random order with repeats, then missing ones
    n = 0;
    while (covered != 9'h1FF && n < 20) begin
      rand_bits(4, r);
      write_seed(int'(r % 9));
      n = n + 1;
    end
    for (int i = 0; i < 9; i++) begin
      if (!covered[i]) begin
        write_seed(i);
      end
    end
    read_reg(1'b1, SEED_0, 32'd0, "dma_rdata_o");

    // Each request moves to the next seed word
    for (int k = 1; k <= 10; k++) begin
      @(posedge clk);
      entropy_req_i <= 1'b1;
      @(posedge clk);
      entropy_req_i <= 1'b0;
      @(negedge clk);
      expect_word("entropy_o", entropy_o, seed_model[k % 9]);
    end

    if (fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "Errors were reported");
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
aes_wrap_pkg.sv
reg_bus_if.sv
cif_req_mux.sv
aes_wrap_regs.sv
key_load.sv
entropy_seed_buffer.sv
aes_wrap_top.sv
tb_aes_wrap.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AES wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_aes_wrap -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
